// ==== board_stimulus.txt ====
# S <24-bit microphone sample, hex> <button[0] pin level, 0 = pressed>
# E <expected held peak of the window just finished, hex>
# Window 1, small positive samples
S 012345 1
S 0A0000 1
S 003000 1
S 07F000 1
E 0A00
# Window 2, most negative sample saturates
S 800000 1
S FF0000 1
S F00000 1
S 123456 1
E 7FFF
# Window 3, listen-through on
S 4C1234 0
S 3000FF 0
S 201000 0
S 5AB000 0
E 5AB0
# Window 4, negative peaks with listen-through on
S C00000 0
S 9ABCDE 0
S 7FFFFF 0
S 800100 0
E 7FFF
# Window 5, tiny values after release
S 000100 1
S FFFF00 1
S 000000 1
S 00FF00 1
E 00FF
# Window 6, peak clears between windows
S 000000 1
S 1FFFFF 1
S 000000 1
S 000000 1
E 1FFF

// ==== vlog.f ====
board_pkg.sv
window_strobe_gen.sv
mic_i2s_receiver.sv
level_meter.sv
static_seg_latch.sv
i2s_audio_out.sv
board_specific_top.sv
tb_clock_gen.sv
tb_board_assertions.sv
tb_board.sv

// ==== tb_board.sv ====
`timescale 1ns/1ps

module tb_board;

    localparam int clk_mhz       = 1;
    localparam int window_hz     = 1000;
    localparam int w_key         = 3;
    localparam int w_sw          = 10;
    localparam int w_led         = 10;
    localparam int w_digit       = 4;
    localparam int window_clocks = clk_mhz * 1_000_000 / window_hz;
    localparam int frame_clocks  = board_pkg::mic_sck_div * board_pkg::mic_frame_bits;
    localparam int n_mic_bits    = $bits(board_pkg::mic_sample_t);
    localparam int settle_clocks = 20;              // Hold to all four digits latched
    localparam int reset_cycles  = 16;
    localparam int history_depth = 3;               // DAC words lag the sample by up to two

    logic               clk;
    logic [w_sw  - 1:0] sw;
    logic [w_key - 1:0] button;
    logic [w_led - 1:0] ledg;
    logic [6:0]         hex0_d;
    logic [6:0]         hex1_d;
    logic [6:0]         hex2_d;
    logic [6:0]         hex3_d;
    logic               hex0_dp;
    logic               hex1_dp;
    logic               hex2_dp;
    logic               hex3_dp;
    logic               mic_lr;
    logic               mic_ws;
    logic               mic_sck;
    logic               mic_sd;
    logic               dac_mclk;
    logic               dac_bclk;
    logic               dac_lrclk;
    logic               dac_sdata;

    board_pkg::mic_sample_t   samples [$];
    logic                     button_levels [$];
    board_pkg::audio_sample_t file_peaks [$];
    board_pkg::audio_sample_t window_peaks [$]; // Recomputed from the samples
    board_pkg::audio_sample_t recent_sound [$];

    int   cyc;
    int   timeout_limit;
    int   value_errors;
    int   other_errors;
    int   frame_idx;
    int   slot;
    int   check_at;
    int   checked;
    int   dac_bits;
    int   dac_live_words;
    logic prev_sck;
    logic prev_ws;
    logic prev_bclk;
    logic prev_lrclk;
    logic prev_mclk;
    logic timed_out;

    board_pkg::audio_sample_t running_peak;
    board_pkg::audio_sample_t dac_shift;

    tb_clock_gen #( .period_ns ( 4.0 ) ) i_clock ( .clk ( clk ) );

    board_specific_top
    #(
        .clk_mhz   ( clk_mhz   ),
        .window_hz ( window_hz ),
        .w_key     ( w_key     ),
        .w_sw      ( w_sw      ),
        .w_led     ( w_led     ),
        .w_digit   ( w_digit   )
    )
    uut
    (
        .clk       ( clk       ),
        .sw        ( sw        ),
        .button    ( button    ),
        .ledg      ( ledg      ),
        .hex0_d    ( hex0_d    ),
        .hex1_d    ( hex1_d    ),
        .hex2_d    ( hex2_d    ),
        .hex3_d    ( hex3_d    ),
        .hex0_dp   ( hex0_dp   ),
        .hex1_dp   ( hex1_dp   ),
        .hex2_dp   ( hex2_dp   ),
        .hex3_dp   ( hex3_dp   ),
        .mic_lr    ( mic_lr    ),
        .mic_ws    ( mic_ws    ),
        .mic_sck   ( mic_sck   ),
        .mic_sd    ( mic_sd    ),
        .dac_mclk  ( dac_mclk  ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata )
    );

    //----------------------------------------------------------------------
    // Reference rules

    // Upper 16 bits as a signed value, absolute, limited to 7FFF
    function automatic board_pkg::audio_sample_t peak_magnitude(input logic [23:0] word);
        int v;
        v = int'($signed(word[23:8]));
        if (v < 0)
            v = -v;
        if (v > 32767)
            v = 32767;
        return v[15:0];
    endfunction

    function automatic int decode_digit(input logic [6:0] pins);
        board_pkg::seg_t glyph;
        logic [6:0]      lit;
        for (int v = 0; v < 16; v++)
        begin
            glyph = board_pkg::seg_font[v];
            for (int k = 0; k < 7; k++)
                lit[k] = ~glyph[7 - k];             // Pin k is segment a + k, low is on
            if (pins == lit)
                return v;
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] wanted);
        assert (got === wanted)
        else
        begin
            value_errors++;
            $display("Fail %s: expected %h, got %h", name, wanted, got);
        end
    endtask

    task automatic record_sound(input board_pkg::audio_sample_t value);
        recent_sound.push_back(value);
        if (recent_sound.size() > history_depth)
            void'(recent_sound.pop_front());
    endtask

    //----------------------------------------------------------------------
    // Stimulus file

    task automatic read_stimulus();
        int          fd;
        int          n;
        int          level;
        string       line;
        logic [23:0] word;
        logic [15:0] peak;
        fd = $fopen("board_stimulus.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open board_stimulus.txt");
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0)
                continue;
            if (line.getc(0) == "S")
            begin
                n = $sscanf(line, "S %h %d", word, level);
                samples.push_back(word);
                button_levels.push_back(level[0]);
            end
            else if (line.getc(0) == "E")
            begin
                n = $sscanf(line, "E %h", peak);
                file_peaks.push_back(peak);
            end
        end
        $fclose(fd);
    endtask

    //----------------------------------------------------------------------
    // Board models

    task automatic apply_button();
        logic level;
        level = (frame_idx < button_levels.size()) ? button_levels[frame_idx] : 1'b1;
        if (level && !button[0])
            record_sound('0);                       // Release silences the DAC at once
        button[0] = level;
    endtask

    // Slot k of a frame starts at the k-th falling sck after ws falls
    task automatic model_microphone();
        board_pkg::mic_sample_t word;
        if (prev_sck && !mic_sck)
        begin
            if (prev_ws && !mic_ws)
            begin
                frame_idx++;
                slot = 0;
                apply_button();
            end
            else
                slot++;
            if (slot == n_mic_bits + 1 && frame_idx < samples.size())
            begin
                word = samples[frame_idx];          // Last bit taken, sample complete
                if (peak_magnitude(word) > running_peak)
                    running_peak = peak_magnitude(word);
                record_sound(!button[0] ? word[23:8] : 16'h0000);
            end
        end
        prev_sck = mic_sck;
        prev_ws  = mic_ws;
        if (slot >= 1 && slot <= n_mic_bits && frame_idx < samples.size())
            mic_sd = samples[frame_idx][n_mic_bits - slot];
        else
            mic_sd = 1'b0;
    endtask

    // A word ends with the bit after the next lrclk change
    task automatic monitor_dac();
        logic known;
        if (!prev_bclk && dac_bclk)
        begin
            dac_shift = { dac_shift[14:0], dac_sdata };
            dac_bits++;
            if (dac_lrclk != prev_lrclk && dac_bits >= 16)
            begin
                known = 1'b0;
                foreach (recent_sound[i])
                    if (recent_sound[i] == dac_shift)
                        known = 1'b1;
                if (known && dac_shift != '0)
                    dac_live_words++;
                assert (known)
                else
                begin
                    value_errors++;
                    $display("Fail dac_sdata: word %h, latest sample %h",
                             dac_shift, recent_sound[$]);
                end
            end
            prev_lrclk = dac_lrclk;
        end
        prev_bclk = dac_bclk;
    endtask

    //----------------------------------------------------------------------
    // Display and LED checks

    task automatic check_display(input board_pkg::audio_sample_t peak_expected, input int idx);
        int               digits [4];
        logic [15:0]      shown;
        int               lit;
        logic [w_led-1:0] bar;
        digits[0] = decode_digit(hex0_d);
        digits[1] = decode_digit(hex1_d);
        digits[2] = decode_digit(hex2_d);
        digits[3] = decode_digit(hex3_d);
        shown = '0;
        for (int d = 0; d < 4; d++)
        begin
            assert (digits[d] >= 0)
            else
            begin
                other_errors++;
                $display("Digit %0d shows no hex glyph after window %0d", d, idx + 1);
            end
            shown[4 * d +: 4] = digits[d][3:0];
        end
        if (idx < file_peaks.size())
            assert (file_peaks[idx] == peak_expected)
            else
            begin
                other_errors++;
                $display("Stimulus file lists %h for window %0d but its samples give %h",
                         file_peaks[idx], idx + 1, peak_expected);
            end
        check_value("hex3_d..hex0_d", shown, peak_expected);
        lit = peak_expected[15:12];
        if (lit > w_led)
            lit = w_led;
        bar = '0;
        for (int i = 0; i < lit; i++)
            bar[i] = 1'b1;                          // Bar grows from bit 0
        check_value("ledg", 16'(ledg), 16'(bar));
    endtask

    task automatic track_windows();
        if (cyc % window_clocks == 0)
        begin
            window_peaks.push_back(running_peak);   // Samples of this cycle count as old
            running_peak = '0;
            check_at = cyc + settle_clocks;
        end
        if (cyc == check_at)
        begin
            check_display(window_peaks[checked], checked);
            checked++;
        end
    endtask

    // Outputs with a fixed rule in every cycle
    task automatic check_fixed_outputs();
        check_value("hex_dp", 16'({ hex3_dp, hex2_dp, hex1_dp, hex0_dp }), 16'h000f);
        check_value("mic_lr", 16'(mic_lr), 16'h0000);
        check_value("dac_mclk", 16'(dac_mclk), prev_mclk ? 16'h0000 : 16'h0001);
        prev_mclk = dac_mclk;                       // Half the system clock
    endtask

    task automatic check_reset_state();
        check_value("hex0_d", 16'(hex0_d), 16'h007f);
        check_value("hex1_d", 16'(hex1_d), 16'h007f);
        check_value("hex2_d", 16'(hex2_d), 16'h007f);
        check_value("hex3_d", 16'(hex3_d), 16'h007f);
        check_value("hex_dp", 16'({ hex3_dp, hex2_dp, hex1_dp, hex0_dp }), 16'h000f);
        check_value("ledg", 16'(ledg), 16'h0000);
        check_value("dac_sdata", 16'(dac_sdata), 16'h0000);
        check_value("dac_bclk", 16'(dac_bclk), 16'h0000);
        check_value("mic_sck", 16'(mic_sck), 16'h0000);
        check_value("mic_ws", 16'(mic_ws), 16'h0000);
        check_value("mic_lr", 16'(mic_lr), 16'h0000);
    endtask

    task automatic finish_run(input logic run_timed_out);
        int total;
        total = value_errors + other_errors + uut.i_assertions.violations;
        $display("Errors: %0d value, %0d other, %0d assertion, timeout %0d",
                 value_errors, other_errors, uut.i_assertions.violations, run_timed_out);
        if (run_timed_out || total > 0)
            $display("Simulation failed");
        else
            $display("Simulation completed successfully");
        $finish;
    endtask

    //----------------------------------------------------------------------
    // Main sequence, everything runs on the falling clock edge

    initial
    begin
        sw             = '0;
        sw[w_sw - 1]   = 1'b1;                      // Top switch is reset
        button         = '1;                        // All buttons released
        mic_sd         = 1'b0;
        cyc            = 0;
        value_errors   = 0;
        other_errors   = 0;
        frame_idx      = 0;
        slot           = 0;
        check_at       = -1;
        checked        = 0;
        dac_bits       = 0;
        dac_live_words = 0;
        prev_sck       = 1'b0;
        prev_ws        = 1'b0;
        prev_bclk      = 1'b0;
        prev_lrclk     = 1'b0;
        prev_mclk      = 1'b0;
        timed_out      = 1'b0;
        running_peak   = '0;
        dac_shift      = '0;
        recent_sound.push_back('0);

        read_stimulus();
        timeout_limit = 3 * samples.size() * frame_clocks / 2 + 100;

        repeat (reset_cycles - 1)
            @(negedge clk);
        check_reset_state();
        @(negedge clk);
        sw[w_sw - 1] = 1'b0;
        apply_button();                             // Frame 0 starts with reset release

        while (file_peaks.size() > 0 && checked < file_peaks.size() && cyc < timeout_limit)
        begin
            @(negedge clk);
            cyc++;
            model_microphone();
            monitor_dac();
            track_windows();
            check_fixed_outputs();
        end

        if (file_peaks.size() == 0)
        begin
            other_errors++;
            $display("No expected window peaks were read");
        end
        else if (checked < file_peaks.size())
        begin
            timed_out = 1'b1;
            $display("Timeout after %0d cycles with %0d of %0d windows checked",
                     cyc, checked, file_peaks.size());
        end
        assert (dac_live_words > 0)
        else
        begin
            other_errors++;
            $display("No listen-through audio reached the DAC");
        end
        finish_run(timed_out);
    end

endmodule

// ==== tb_board_assertions.sv ====
`timescale 1ns/1ps

module tb_board_assertions
(
    input logic       clk,
    input logic       rst,
    input logic       mic_ws,
    input logic       mic_sck,
    input logic       dac_lrclk,
    input logic       dac_bclk,
    input logic [6:0] hex0_d,
    input logic [6:0] hex1_d,
    input logic [6:0] hex2_d,
    input logic [6:0] hex3_d,
    input logic       hex0_dp,
    input logic       hex1_dp,
    input logic       hex2_dp,
    input logic       hex3_dp
);

    int violations = 0;                             // Failed assertions so far

    //----------------------------------------------------------------------
    // Word clocks move only with the falling bit clock

    property ws_on_sck_fall;
        @(posedge clk) disable iff (rst)
            $changed(mic_ws) |-> $fell(mic_sck);
    endproperty

    property lrclk_on_bclk_fall;
        @(posedge clk) disable iff (rst)
            $changed(dac_lrclk) |-> $fell(dac_bclk);
    endproperty

    // The scan loads one digit register at a time
    property one_digit_per_clock;
        @(posedge clk) disable iff (rst)
            $onehot0({ $changed({ hex3_dp, hex3_d }),
                       $changed({ hex2_dp, hex2_d }),
                       $changed({ hex1_dp, hex1_d }),
                       $changed({ hex0_dp, hex0_d }) });
    endproperty

    mic_ws_timing: assert property (ws_on_sck_fall)
    else
    begin
        violations++;
        $error("mic_ws changed away from a falling mic_sck edge");
    end

    dac_lrclk_timing: assert property (lrclk_on_bclk_fall)
    else
    begin
        violations++;
        $error("dac_lrclk changed away from a falling dac_bclk edge");
    end

    digit_load_order: assert property (one_digit_per_clock)
    else
    begin
        violations++;
        $error("More than one hex digit register changed in one clock");
    end

endmodule

bind board_specific_top tb_board_assertions i_assertions
(
    .clk       ( clk       ),
    .rst       ( rst       ),
    .mic_ws    ( mic_ws    ),
    .mic_sck   ( mic_sck   ),
    .dac_lrclk ( dac_lrclk ),
    .dac_bclk  ( dac_bclk  ),
    .hex0_d    ( hex0_d    ),
    .hex1_d    ( hex1_d    ),
    .hex2_d    ( hex2_d    ),
    .hex3_d    ( hex3_d    ),
    .hex0_dp   ( hex0_dp   ),
    .hex1_dp   ( hex1_dp   ),
    .hex2_dp   ( hex2_dp   ),
    .hex3_dp   ( hex3_dp   )
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter real period_ns = 4.0
)
(
    output logic clk
);

    initial
        clk = 1'b0;

    always
        #(period_ns / 2.0) clk = ~clk;              // Free-running, 50 % duty

endmodule

// ==== board_specific_top.sv ====
`timescale 1ns/1ps

module board_specific_top
#(
    parameter clk_mhz   = 50,
    parameter window_hz = 10,
    parameter w_key     = 3,
    parameter w_sw      = 10,
    parameter w_led     = 10,
    parameter w_digit   = 4
)
(
    input  logic               clk,

    input  logic [w_sw  - 1:0] sw,
    input  logic [w_key - 1:0] button,
    output logic [w_led - 1:0] ledg,

    output logic [        6:0] hex0_d,
    output logic [        6:0] hex1_d,
    output logic [        6:0] hex2_d,
    output logic [        6:0] hex3_d,
    output logic               hex0_dp,
    output logic               hex1_dp,
    output logic               hex2_dp,
    output logic               hex3_dp,

    output logic               mic_lr,
    output logic               mic_ws,
    output logic               mic_sck,
    input  logic               mic_sd,

    output logic               dac_mclk,
    output logic               dac_bclk,
    output logic               dac_lrclk,
    output logic               dac_sdata
);

    //----------------------------------------------------------------------
    // Board conventions

    logic                 rst;
    logic [w_key   - 1:0] key;

    assign rst = sw[w_sw - 1];                  // Top switch resets the design
    assign key = ~button;                       // Buttons pull low when pressed

    //----------------------------------------------------------------------

    board_pkg::mic_sample_t   mic_value;
    logic                     mic_valid;
    logic                     window_strobe;
    board_pkg::seg_t          abcdefgh;
    logic [w_digit - 1:0]     digit;
    board_pkg::audio_sample_t sound;

    window_strobe_gen
    #(
        .clk_mhz   ( clk_mhz   ),
        .window_hz ( window_hz )
    )
    i_window_strobe_gen
    (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .window_strobe ( window_strobe )
    );

    mic_i2s_receiver i_mic
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .sck   ( mic_sck   ),
        .ws    ( mic_ws    ),
        .lr    ( mic_lr    ),
        .sd    ( mic_sd    ),
        .value ( mic_value ),
        .valid ( mic_valid )
    );

    level_meter
    #(
        .w_key   ( w_key   ),
        .w_led   ( w_led   ),
        .w_digit ( w_digit )
    )
    i_level_meter
    (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .key           ( key           ),
        .mic_value     ( mic_value     ),
        .mic_valid     ( mic_valid     ),
        .window_strobe ( window_strobe ),
        .led           ( ledg          ),
        .abcdefgh      ( abcdefgh      ),
        .digit         ( digit         ),
        .sound         ( sound         )
    );

    static_seg_latch #( .w_digit ( w_digit ) ) i_seg_latch
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .hex0_d   ( hex0_d   ),
        .hex1_d   ( hex1_d   ),
        .hex2_d   ( hex2_d   ),
        .hex3_d   ( hex3_d   ),
        .hex0_dp  ( hex0_dp  ),
        .hex1_dp  ( hex1_dp  ),
        .hex2_dp  ( hex2_dp  ),
        .hex3_dp  ( hex3_dp  )
    );

    i2s_audio_out i_audio_out
    (
        .clk     ( clk       ),
        .rst     ( rst       ),
        .data_in ( sound     ),
        .mclk    ( dac_mclk  ),
        .bclk    ( dac_bclk  ),
        .lrclk   ( dac_lrclk ),
        .sdata   ( dac_sdata )
    );

endmodule

// ==== i2s_audio_out.sv ====
`timescale 1ns/1ps

module i2s_audio_out
(
    input  logic                     clk,
    input  logic                     rst,

    input  board_pkg::audio_sample_t data_in,

    output logic                     mclk,
    output logic                     bclk,
    output logic                     lrclk,
    output logic                     sdata
);

    //----------------------------------------------------------------------
    // All three DAC clocks come from one frame counter

    localparam int w_div  = $clog2(board_pkg::bclk_div);
    localparam int w_cnt  = $clog2(board_pkg::bclk_div * board_pkg::dac_frame_bits);
    localparam int w_slot = w_cnt - 1 - w_div;  // Bit position within a channel
    localparam int n_bits = $bits(board_pkg::audio_sample_t);

    logic [w_cnt  - 1:0] cnt;
    logic [w_cnt  - 1:0] cnt_next;
    logic [w_slot - 1:0] slot_next;
    logic                bclk_fall;

    board_pkg::audio_sample_t sample_q;

    always_ff @(posedge clk or posedge rst)
        if (rst)
            cnt <= '0;
        else
            cnt <= cnt_next;

    assign cnt_next = cnt + 1'b1;

    assign mclk  = cnt[0];                      // clk / 2
    assign bclk  = cnt[w_div - 1];
    assign lrclk = cnt[w_cnt - 1];              // Low for the left channel

    assign bclk_fall = (cnt[w_div - 1:0] == '1);
    assign slot_next = cnt_next[w_cnt - 2:w_div];

    //----------------------------------------------------------------------
    // Capture at frame start, shift out on falling bclk

    always_ff @(posedge clk or posedge rst)
        if (rst)
            sample_q <= '0;
        else if (cnt == '1)
            sample_q <= data_in;                // lrclk is about to fall

    // Slot 0 carries the LSB of the word before, as I2S delays by one bit
    always_ff @(posedge clk or posedge rst)
        if (rst)
            sdata <= 1'b0;
        else if (bclk_fall)
        begin
            if (slot_next == '0)
                sdata <= sample_q[0];
            else
                sdata <= sample_q[n_bits - int'(slot_next)];
        end

endmodule

// ==== static_seg_latch.sv ====
`timescale 1ns/1ps

module static_seg_latch
#(
    parameter w_digit = 4
)
(
    input  logic                 clk,
    input  logic                 rst,

    input  board_pkg::seg_t      abcdefgh,
    input  logic [w_digit - 1:0] digit,

    output logic [6:0]           hex0_d,
    output logic [6:0]           hex1_d,
    output logic [6:0]           hex2_d,
    output logic [6:0]           hex3_d,
    output logic                 hex0_dp,
    output logic                 hex1_dp,
    output logic                 hex2_dp,
    output logic                 hex3_dp
);

    //----------------------------------------------------------------------
    // Board wires segment a to bit 0 and the decimal point to bit 7

    localparam int w_seg = $bits(board_pkg::seg_t);

    board_pkg::seg_t hgfedcba;
    board_pkg::seg_t digit_q [w_digit];         // Active-low, one per digit

    always_comb
        for (int i = 0; i < w_seg; i++)
            hgfedcba[i] = abcdefgh[w_seg - 1 - i];

    //----------------------------------------------------------------------
    // Sticky latches keep each digit lit between scans

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            for (int d = 0; d < w_digit; d++)
                digit_q[d] <= '1;               // All segments dark
        end
        else
        begin
            for (int d = 0; d < w_digit; d++)
                if (digit[d])
                    digit_q[d] <= ~hgfedcba;
        end

    assign hex0_d  = digit_q[0][6:0];
    assign hex1_d  = digit_q[1][6:0];
    assign hex2_d  = digit_q[2][6:0];
    assign hex3_d  = digit_q[3][6:0];

    assign hex0_dp = digit_q[0][7];
    assign hex1_dp = digit_q[1][7];
    assign hex2_dp = digit_q[2][7];
    assign hex3_dp = digit_q[3][7];

endmodule

// ==== level_meter.sv ====
`timescale 1ns/1ps

module level_meter
#(
    parameter w_key   = 3,
    parameter w_led   = 10,
    parameter w_digit = 4
)
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic [w_key   - 1:0]     key,
    input  board_pkg::mic_sample_t   mic_value,
    input  logic                     mic_valid,
    input  logic                     window_strobe,

    output logic [w_led   - 1:0]     led,
    output board_pkg::seg_t          abcdefgh,
    output logic [w_digit - 1:0]     digit,
    output board_pkg::audio_sample_t sound
);

    //----------------------------------------------------------------------
    // Peak detection

    board_pkg::audio_sample_t upper;
    board_pkg::audio_sample_t mag;
    board_pkg::audio_sample_t candidate;
    board_pkg::audio_sample_t peak;
    board_pkg::audio_sample_t held;

    assign upper = mic_value[23:8];

    always_comb
    begin
        if (!upper[15])
            mag = upper;
        else if (upper == 16'h8000)
            mag = 16'h7FFF;                     // Most negative value saturates
        else
            mag = -upper;
    end

    // A sample arriving with the strobe still belongs to the old window
    assign candidate = (mic_valid && mag > peak) ? mag : peak;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            peak <= '0;
            held <= '0;
        end
        else if (window_strobe)
        begin
            held <= candidate;
            peak <= '0;
        end
        else
            peak <= candidate;

    //----------------------------------------------------------------------
    // Digit scan and font lookup

    logic [1:0]         scan_div;
    board_pkg::nibble_t nibble;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            scan_div <= '0;
            digit    <= w_digit'(1);
        end
        else
        begin
            scan_div <= scan_div + 1'b1;
            if (scan_div == 2'b11)
                digit <= { digit[w_digit - 2:0], digit[w_digit - 1] };  // Next digit
        end

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < w_digit; i++)
            if (digit[i])
                nibble = held[4 * i +: 4];
        abcdefgh = board_pkg::seg_font[nibble];
    end

    //----------------------------------------------------------------------
    // LED bar and listen-through

    always_ff @(posedge clk or posedge rst)
        if (rst)
            led <= '0;
        else
            for (int i = 0; i < w_led; i++)
                led[i] <= (held[15:12] > i);    // Bar length is held / 4096

    always_ff @(posedge clk or posedge rst)
        if (rst)
            sound <= '0;
        else if (!key[0])
            sound <= '0;                        // Silent while released
        else if (mic_valid)
            sound <= upper;

endmodule

// ==== mic_i2s_receiver.sv ====
`timescale 1ns/1ps

module mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst,

    output logic                   sck,
    output logic                   ws,
    output logic                   lr,
    input  logic                   sd,

    output board_pkg::mic_sample_t value,
    output logic                   valid
);

    //----------------------------------------------------------------------
    // One counter spans a whole frame: low bits make sck, high bits the slot

    localparam int w_div   = $clog2(board_pkg::mic_sck_div);
    localparam int w_cnt   = $clog2(board_pkg::mic_sck_div * board_pkg::mic_frame_bits);
    localparam int w_bit   = w_cnt - w_div;
    localparam int n_bits  = $bits(board_pkg::mic_sample_t);
    localparam int rise_ph = board_pkg::mic_sck_div / 2 - 1;

    logic [w_cnt - 1:0] cnt;
    logic [w_div - 1:0] phase;
    logic [w_bit - 1:0] bit_idx;
    logic               sample_now;
    logic               frame_done;

    board_pkg::mic_sample_t shift;

    always_ff @(posedge clk or posedge rst)
        if (rst)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;

    assign phase   = cnt[w_div - 1:0];
    assign bit_idx = cnt[w_cnt - 1:w_div];

    assign sck = cnt[w_div - 1];                // Low half then high half
    assign ws  = cnt[w_cnt - 1];                // Low for the left slot
    assign lr  = 1'b0;                          // Microphone answers in left slot

    // Data bits sit in slots 1 to 24, sampled as sck rises
    assign sample_now = (phase == w_div'(rise_ph))
                      && (bit_idx >= w_bit'(1))
                      && (bit_idx <= w_bit'(n_bits));

    // One clock after the last bit was taken
    assign frame_done = (bit_idx == w_bit'(n_bits)) && (phase == w_div'(rise_ph + 1));

    always_ff @(posedge clk)
        if (sample_now)
            shift <= { shift[n_bits - 2:0], sd };   // MSB first

    always_ff @(posedge clk)
        if (frame_done)
            value <= shift;

    always_ff @(posedge clk or posedge rst)
        if (rst)
            valid <= 1'b0;
        else
            valid <= frame_done;

endmodule

// ==== window_strobe_gen.sv ====
`timescale 1ns/1ps

module window_strobe_gen
#(
    parameter clk_mhz   = 50,
    parameter window_hz = 10
)
(
    input  logic clk,
    input  logic rst,
    output logic window_strobe
);

    localparam int period = clk_mhz * 1_000_000 / window_hz;
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk or posedge rst)
        if (rst)
            cnt <= w_cnt'(period - 1);
        else if (cnt == '0)
            cnt <= w_cnt'(period - 1);          // Reload at terminal count
        else
            cnt <= cnt - 1'b1;

    assign window_strobe = (cnt == '0);         // One cycle per window

endmodule

// ==== board_pkg.sv ====
package board_pkg;

    //----------------------------------------------------------------------
    // Data widths

    typedef logic signed [23:0] mic_sample_t;      // Raw INMP441 word
    typedef logic        [15:0] audio_sample_t;    // DAC word and peak magnitude
    typedef logic        [ 7:0] seg_t;             // a..g in 7:1, dp in bit 0
    typedef logic        [ 3:0] nibble_t;

    //----------------------------------------------------------------------
    // Clock ratios of the serial audio links

    localparam int mic_sck_div    = 4;             // clk cycles per mic bit clock
    localparam int mic_frame_bits = 64;            // Two 32-bit slots
    localparam int bclk_div       = 4;             // clk cycles per DAC bit clock
    localparam int dac_frame_bits = 32;            // Two 16-bit slots

    //----------------------------------------------------------------------
    // Hex glyphs, segment a in the MSB

    localparam seg_t seg_font [16] = '{
        8'b1111_1100,                              // 0
        8'b0110_0000,                              // 1
        8'b1101_1010,                              // 2
        8'b1111_0010,                              // 3
        8'b0110_0110,                              // 4
        8'b1011_0110,                              // 5
        8'b1011_1110,                              // 6
        8'b1110_0000,                              // 7
        8'b1111_1110,                              // 8
        8'b1111_0110,                              // 9
        8'b1110_1110,                              // A
        8'b0011_1110,                              // b
        8'b1001_1100,                              // C
        8'b0111_1010,                              // d
        8'b1001_1110,                              // E
        8'b1000_1110                               // F
    };

endpackage
